//--- all.f
hw/serv_pkg.sv
hw/serv_exec_if.sv
hw/serv_state.sv
hw/serv_decode.sv
hw/serv_alu.sv
hw/serv_rf.sv
hw/serv_ctrl.sv
hw/serv_mem_if.sv
hw/serv_top.sv
verif/tb_serv.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_serv -f all.f -o tb_serv || exit 1
out=$(./obj_dir/tb_serv)
echo "$out"
echo "$out" | grep -qx "Simulation PASSED" && exit 0 || exit 1

//--- verif/serv_patterns.txt
// Word 0 is the program length, word 1 the store record count, then the program words,
// then one store record per line as address and data
00000017
0000000a
10000513 // addi x10, x0, 256
06400093 // addi x1, x0, 100
ff900113 // addi x2, x0, -7
002081b3 // add  x3, x1, x2
00352023 // sw   x3, 0(x10)
40208233 // sub  x4, x1, x2
00452223 // sw   x4, 4(x10)
0020f2b3 // and  x5, x1, x2
00552423 // sw   x5, 8(x10)
0020e333 // or   x6, x1, x2
00652623 // sw   x6, 12(x10)
0020c3b3 // xor  x7, x1, x2
00752823 // sw   x7, 16(x10)
f3808413 // addi x8, x1, -200
fe852e23 // sw   x8, -4(x10)
fff0c493 // xori x9, x1, -1
fe952c23 // sw   x9, -8(x10)
ff017593 // andi x11, x2, -16
00b52a23 // sw   x11, 20(x10)
f000e613 // ori  x12, x1, -256
00c52c23 // sw   x12, 24(x10)
00508013 // addi x0, x1, 5
00052e23 // sw   x0, 28(x10)
00000100 0000005d
00000104 0000006b
00000108 00000060
0000010c fffffffd
00000110 ffffff9d
000000fc ffffff9c
000000f8 ffffff9b
00000114 fffffff0
00000118 ffffff64
0000011c 00000000

//--- verif/tb_serv.sv
`timescale 1ns/1ps
`default_nettype none

module tb_serv;

   localparam logic [31:0] RESET_PC   = 32'h0000_0000;
   localparam logic [31:0] NOP_WORD   = 32'h0000_0013;
   localparam int          TAIL_FETCH = 8;
   localparam int          WAIT_LIMIT = 200;

   logic        i_clk;
   logic        i_rst;
   logic [31:0] i_ibus_rdt = '0;
   logic        i_ibus_ack = 1'b0;
   logic        i_dbus_ack = 1'b0;
   logic        o_ibus_cyc;
   logic [31:0] o_ibus_adr;
   logic        o_dbus_cyc;
   logic        o_dbus_we;
   logic [31:0] o_dbus_adr;
   logic [31:0] o_dbus_dat;
   logic [3:0]  o_dbus_sel;

   logic [31:0] pat [0:63];
   int          prog_len;
   int          rec_count;
   int          errors;
   int          checks;
   bit          timed_out;
   bit          rand_mode;
   int          ibus_wait;
   int          dbus_wait;
   logic [15:0] lfsr = 16'd23;

   serv_top #(
      .RESET_PC (RESET_PC)
   ) dut_i (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .o_ibus_cyc (o_ibus_cyc),
      .o_ibus_adr (o_ibus_adr),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_dbus_cyc (o_dbus_cyc),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_sel (o_dbus_sel),
      .i_dbus_ack (i_dbus_ack)
   );

   always #4 i_clk = ~i_clk;

   function automatic logic lfsr_step();
      logic out_bit;
      out_bit = lfsr[0];
      lfsr = {1'b0, lfsr[15:1]};
      if (out_bit) begin
         lfsr = lfsr ^ 16'hB400;
      end
      return out_bit;
   endfunction

   // Two bits per delay, 0 to 3 cycles
   function automatic int ack_delay();
      int d;
      d = 0;
      if (rand_mode) begin
         d = lfsr_step() ? 2 : 0;
         d = d + (lfsr_step() ? 1 : 0);
      end
      return d;
   endfunction

   function automatic logic [31:0] fetch_word(input logic [31:0] adr);
      int idx;
      idx = int'(adr >> 2);
      if (idx < prog_len) begin
         return pat[2 + idx];
      end
      return NOP_WORD;
   endfunction

   // Bus slaves for both buses
   always @(posedge i_clk) begin
      i_ibus_ack <= 1'b0;
      i_dbus_ack <= 1'b0;
      if (i_rst) begin
         ibus_wait = -1;
         dbus_wait = -1;
      end else begin
         if (o_ibus_cyc && !i_ibus_ack) begin
            if (ibus_wait < 0) begin
               ibus_wait = ack_delay();
            end
            if (ibus_wait == 0) begin
               i_ibus_rdt <= fetch_word(o_ibus_adr);
               i_ibus_ack <= 1'b1;
            end
            ibus_wait = ibus_wait - 1;
         end
         if (o_dbus_cyc && !i_dbus_ack) begin
            if (dbus_wait < 0) begin
               dbus_wait = ack_delay();
            end
            if (dbus_wait == 0) begin
               i_dbus_ack <= 1'b1;
            end
            dbus_wait = dbus_wait - 1;
         end
      end
   end

   task automatic check_word(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      checks++;
      assert (actual === expected) else begin
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic report_problem(input string text);
      $display("ERROR: %s", text);
      errors++;
   endtask

   task automatic report_test(input string name, input int fails);
      if (fails == 0) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, fails);
      end
   endtask

   // A transfer completes at the next rising edge when cyc and ack are both high
   task automatic wait_transfer(output bit ok);
      int n;
      ok = 1'b0;
      for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
         @(negedge i_clk);
         ok = (o_ibus_cyc && i_ibus_ack) || (o_dbus_cyc && i_dbus_ack);
      end
   endtask

   task automatic run_pass(input string tag, input bit use_random);
      logic [31:0] expected_pc;
      int          fetches;
      int          rec;
      int          extra;
      int          base;
      int          fetch_bad;
      int          mark;
      bit          ok;
      string       name;

      rand_mode = use_random;
      @(posedge i_clk);
      i_rst <= 1'b1;
      repeat (16) begin
         @(posedge i_clk);
      end
      i_rst <= 1'b0;

      mark = errors;
      @(negedge i_clk);
      check_word($sformatf("%s_reset_dbus_cyc", tag), 32'd0, {31'd0, o_dbus_cyc});
      check_word($sformatf("%s_reset_ibus_cyc", tag), 32'd1, {31'd0, o_ibus_cyc});
      check_word($sformatf("%s_reset_pc", tag), RESET_PC, o_ibus_adr);
      report_test($sformatf("%s_reset", tag), errors - mark);

      expected_pc = RESET_PC;
      fetches = 0;
      rec = 0;
      extra = 0;
      fetch_bad = 0;
      base = 2 + prog_len;
      while (fetches < prog_len + TAIL_FETCH) begin
         wait_transfer(ok);
         if (!ok) begin
            report_problem($sformatf("%s: no bus transfer within %0d cycles",
                                     tag, WAIT_LIMIT));
            timed_out = 1'b1;
            return;
         end
         if (o_ibus_cyc) begin
            mark = errors;
            check_word($sformatf("%s_fetch_%0d", tag, fetches), expected_pc, o_ibus_adr);
            fetch_bad = fetch_bad + errors - mark;
            expected_pc = expected_pc + 32'd4;
            fetches++;
         end else if (rec >= rec_count) begin
            report_problem($sformatf("%s: store to %h beyond the expected records",
                                     tag, o_dbus_adr));
            extra++;
         end else begin
            name = $sformatf("%s_store_%0d", tag, rec);
            mark = errors;
            check_word({name, "_adr"}, pat[base + 2 * rec], o_dbus_adr);
            check_word({name, "_dat"}, pat[base + 2 * rec + 1], o_dbus_dat);
            check_word({name, "_sel"}, 32'hF, {28'd0, o_dbus_sel});
            check_word({name, "_we"}, 32'd1, {31'd0, o_dbus_we});
            report_test(name, errors - mark);
            rec++;
         end
      end
      report_test($sformatf("%s_fetch_sequence", tag), fetch_bad);

      mark = errors;
      check_word($sformatf("%s_store_count", tag), rec_count, rec);
      check_word($sformatf("%s_extra_stores", tag), 32'd0, extra);
      report_test($sformatf("%s_store_count", tag), errors - mark);
   endtask

   initial begin
      i_clk = 1'b0;
      i_rst <= 1'b1;
      errors = 0;
      checks = 0;
      timed_out = 1'b0;
      rand_mode = 1'b0;
      $readmemh("verif/serv_patterns.txt", pat);
      prog_len = int'(pat[0]);
      rec_count = int'(pat[1]);
      if (2 + prog_len + 2 * rec_count > 64) begin
         report_problem("pattern file counts do not fit the pattern memory");
      end else begin
         run_pass("fixed_ack", 1'b0);
         if (!timed_out) begin
            run_pass("random_ack", 1'b1);
         end
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/serv_top.sv
`timescale 1ns/1ps
`default_nettype none

module serv_top #(
   parameter logic [serv_pkg::XLEN-1:0] RESET_PC = '0
) (
   input  logic                      i_clk,
   input  logic                      i_rst,
   output logic                      o_ibus_cyc,
   output logic [serv_pkg::XLEN-1:0] o_ibus_adr,
   input  logic [serv_pkg::XLEN-1:0] i_ibus_rdt,
   input  logic                      i_ibus_ack,
   output logic                      o_dbus_cyc,
   output logic                      o_dbus_we,
   output logic [serv_pkg::XLEN-1:0] o_dbus_adr,
   output logic [serv_pkg::XLEN-1:0] o_dbus_dat,
   output logic [3:0]                o_dbus_sel,
   input  logic                      i_dbus_ack
);
   import serv_pkg::*;

   logic [REG_AW-1:0] rs1_addr;
   logic [REG_AW-1:0] rs2_addr;
   logic [REG_AW-1:0] rd_addr;
   logic              rs1_bit;
   logic              rs2_bit;

   serv_exec_if exec_i ();

   serv_state state_i (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc),
      .exec       (exec_i.state)
   );

   serv_decode decode_i (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_rd_addr  (rd_addr),
      .exec       (exec_i.decode)
   );

   serv_alu alu_i (
      .i_clk     (i_clk),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .exec      (exec_i.alu)
   );

   serv_rf rf_i (
      .i_clk      (i_clk),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_wen      (exec_i.rd_wen),
      .i_wbit     (exec_i.alu_rd),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit),
      .exec       (exec_i.alu)
   );

   serv_ctrl #(
      .RESET_PC (RESET_PC)
   ) ctrl_i (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_pc_en (exec_i.cnt_en),
      .o_pc    (o_ibus_adr)
   );

   serv_mem_if mem_if_i (
      .i_clk      (i_clk),
      .i_rs1_bit  (rs1_bit),
      .i_rs2_bit  (rs2_bit),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_sel (o_dbus_sel),
      .o_dbus_we  (o_dbus_we),
      .exec       (exec_i.mem)
   );

endmodule

`default_nettype wire

//--- hw/serv_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

module serv_mem_if (
   input  logic                      i_clk,
   input  logic                      i_rs1_bit,
   input  logic                      i_rs2_bit,
   output logic [serv_pkg::XLEN-1:0] o_dbus_adr,
   output logic [serv_pkg::XLEN-1:0] o_dbus_dat,
   output logic [3:0]                o_dbus_sel,
   output logic                      o_dbus_we,
   serv_exec_if.mem                  exec
);
   import serv_pkg::*;

   logic [XLEN-1:0] adr_sr;
   logic [XLEN-1:0] dat_sr;
   logic            carry_q;
   logic            cin;
   logic            adr_bit;

   // rs1 + offset
   assign cin     = (exec.cnt == '0) ? 1'b0 : carry_q;
   assign adr_bit = i_rs1_bit ^ exec.imm_bit ^ cin;

   always_ff @(posedge i_clk) begin
      if (exec.cnt_en && exec.is_store) begin
         carry_q <= (i_rs1_bit & exec.imm_bit) | (cin & (i_rs1_bit ^ exec.imm_bit));
         adr_sr  <= {adr_bit, adr_sr[XLEN-1:1]};
         dat_sr  <= {i_rs2_bit, dat_sr[XLEN-1:1]};
      end
   end

   // Word stores only
   assign o_dbus_adr = {adr_sr[XLEN-1:2], 2'b00};
   assign o_dbus_dat = dat_sr;
   assign o_dbus_sel = 4'b1111;
   assign o_dbus_we  = 1'b1;

endmodule

`default_nettype wire

//--- hw/serv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module serv_ctrl #(
   parameter logic [serv_pkg::XLEN-1:0] RESET_PC = '0
) (
   input  logic                      i_clk,
   input  logic                      i_rst,
   input  logic                      i_pc_en,
   output logic [serv_pkg::XLEN-1:0] o_pc
);
   import serv_pkg::*;

   logic [2:0] inc_sr;
   logic       inc_bit;
   logic       pc_bit;
   logic       carry_q;

   // The 4 enters at bit 2
   assign inc_bit = inc_sr[0];
   assign pc_bit  = o_pc[0] ^ inc_bit ^ carry_q;

   // PC rotates once per instruction, new value is whole after the last bit
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_pc    <= RESET_PC;
         inc_sr  <= 3'b100;
         carry_q <= 1'b0;
      end else if (i_pc_en) begin
         o_pc    <= {pc_bit, o_pc[XLEN-1:1]};
         inc_sr  <= {1'b0, inc_sr[2:1]};
         carry_q <= (o_pc[0] & inc_bit) | (carry_q & (o_pc[0] ^ inc_bit));
      end else begin
         inc_sr  <= 3'b100;
         carry_q <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- hw/serv_rf.sv
`timescale 1ns/1ps
`default_nettype none

module serv_rf (
   input  logic                        i_clk,
   input  logic [serv_pkg::REG_AW-1:0] i_rs1_addr,
   input  logic [serv_pkg::REG_AW-1:0] i_rs2_addr,
   input  logic [serv_pkg::REG_AW-1:0] i_rd_addr,
   input  logic                        i_wen,
   input  logic                        i_wbit,
   output logic                        o_rs1_bit,
   output logic                        o_rs2_bit,
   serv_exec_if.alu                    exec
);
   import serv_pkg::*;

   logic [XLEN-1:0] regs [0:(1<<REG_AW)-1];

   // Read sees the old bit when rd equals rs1 or rs2
   assign o_rs1_bit = (i_rs1_addr == '0) ? 1'b0 : regs[i_rs1_addr][exec.cnt];
   assign o_rs2_bit = (i_rs2_addr == '0) ? 1'b0 : regs[i_rs2_addr][exec.cnt];

   always_ff @(posedge i_clk) begin
      if (exec.cnt_en && i_wen && (i_rd_addr != '0)) begin
         regs[i_rd_addr][exec.cnt] <= i_wbit;
      end
   end

endmodule

`default_nettype wire

//--- hw/serv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module serv_alu (
   input  logic     i_clk,
   input  logic     i_rs1_bit,
   input  logic     i_rs2_bit,
   serv_exec_if.alu exec
);
   import serv_pkg::*;

   logic op_b;
   logic sub;
   logic b_add;
   logic cin;
   logic carry_q;

   assign op_b  = exec.op_b_imm ? exec.imm_bit : i_rs2_bit;
   assign sub   = (exec.alu_op == ALU_SUB);
   // Two's complement subtract is invert plus carry in
   assign b_add = op_b ^ sub;
   assign cin   = (exec.cnt == '0) ? sub : carry_q;

   always_ff @(posedge i_clk) begin
      if (exec.cnt_en) begin
         carry_q <= (i_rs1_bit & b_add) | (cin & (i_rs1_bit ^ b_add));
      end
   end

   always_comb begin
      case (exec.alu_op)
         ALU_AND: exec.alu_rd = i_rs1_bit & op_b;
         ALU_OR:  exec.alu_rd = i_rs1_bit | op_b;
         ALU_XOR: exec.alu_rd = i_rs1_bit ^ op_b;
         default: exec.alu_rd = i_rs1_bit ^ b_add ^ cin;
      endcase
   end

endmodule

`default_nettype wire

//--- hw/serv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module serv_decode (
   input  logic                        i_clk,
   input  logic                        i_rst,
   input  logic                        i_ibus_ack,
   input  logic [serv_pkg::XLEN-1:0]   i_ibus_rdt,
   output logic [serv_pkg::REG_AW-1:0] o_rs1_addr,
   output logic [serv_pkg::REG_AW-1:0] o_rs2_addr,
   output logic [serv_pkg::REG_AW-1:0] o_rd_addr,
   serv_exec_if.decode                 exec
);
   import serv_pkg::*;

   logic [6:0]  opcode_q;
   logic [2:0]  funct3_q;
   logic        funct7_b5_q;
   logic [11:0] imm_sr;
   logic        op_rr;
   logic        op_imm;
   logic        funct3_ok;
   logic        fetch_ack;

   // A stray ack during execute leaves the instruction alone
   assign fetch_ack = i_ibus_ack && !exec.cnt_en;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         opcode_q <= '0;
      end else if (fetch_ack) begin
         opcode_q <= i_ibus_rdt[6:0];
      end
   end

   always_ff @(posedge i_clk) begin
      if (fetch_ack) begin
         funct3_q    <= i_ibus_rdt[14:12];
         funct7_b5_q <= i_ibus_rdt[30];
         o_rd_addr   <= i_ibus_rdt[11:7];
         o_rs1_addr  <= i_ibus_rdt[19:15];
         o_rs2_addr  <= i_ibus_rdt[24:20];
      end
   end

   // S-type splits the immediate around rd
   always_ff @(posedge i_clk) begin
      if (fetch_ack) begin
         if (i_ibus_rdt[6:0] == OPC_STORE) begin
            imm_sr <= {i_ibus_rdt[31:25], i_ibus_rdt[11:7]};
         end else begin
            imm_sr <= i_ibus_rdt[31:20];
         end
      end else if (exec.cnt_en) begin
         // Sign bit refills from the top
         imm_sr <= {imm_sr[11], imm_sr[11:1]};
      end
   end

   assign op_rr  = (opcode_q == OPC_OP);
   assign op_imm = (opcode_q == OPC_OPIMM);

   // ADD/SUB, XOR, OR, AND
   assign funct3_ok = (funct3_q == 3'b000) || (funct3_q[2] && (funct3_q[1] || !funct3_q[0]));

   always_comb begin
      case (funct3_q)
         3'b100:  exec.alu_op = ALU_XOR;
         3'b110:  exec.alu_op = ALU_OR;
         3'b111:  exec.alu_op = ALU_AND;
         default: exec.alu_op = (op_rr && funct7_b5_q) ? ALU_SUB : ALU_ADD;
      endcase
   end

   assign exec.op_b_imm = op_imm;
   assign exec.imm_bit  = imm_sr[0];
   assign exec.rd_wen   = (op_rr || op_imm) && funct3_ok;
   // SW only
   assign exec.is_store = (opcode_q == OPC_STORE) && (funct3_q == 3'b010);

endmodule

`default_nettype wire

//--- hw/serv_state.sv
`timescale 1ns/1ps
`default_nettype none

module serv_state (
   input  logic        i_clk,
   input  logic        i_rst,
   input  logic        i_ibus_ack,
   input  logic        i_dbus_ack,
   output logic        o_ibus_cyc,
   output logic        o_dbus_cyc,
   serv_exec_if.state  exec
);
   import serv_pkg::*;

   state_e           state_q;
   logic [CNT_W-1:0] cnt_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state_q <= ST_FETCH;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            ST_FETCH: begin
               cnt_q <= '0;
               if (i_ibus_ack) begin
                  state_q <= ST_EXEC;
               end
            end
            ST_EXEC: begin
               // Wraps to zero after bit 31
               cnt_q <= cnt_q + CNT_W'(1);
               if (exec.cnt_done) begin
                  state_q <= exec.is_store ? ST_STORE : ST_FETCH;
               end
            end
            ST_STORE: begin
               if (i_dbus_ack) begin
                  state_q <= ST_FETCH;
               end
            end
            default: state_q <= ST_FETCH;
         endcase
      end
   end

   assign exec.cnt_en   = (state_q == ST_EXEC);
   assign exec.cnt      = cnt_q;
   assign exec.cnt_done = exec.cnt_en && (cnt_q == '1);

   assign o_ibus_cyc = (state_q == ST_FETCH);
   assign o_dbus_cyc = (state_q == ST_STORE);

   // cyc holds until ack
   assert property (@(posedge i_clk) disable iff (i_rst)
                    o_ibus_cyc && !i_ibus_ack |=> o_ibus_cyc)
      else $error("Instruction bus cycle dropped before ack");

   assert property (@(posedge i_clk) disable iff (i_rst)
                    o_dbus_cyc && !i_dbus_ack |=> o_dbus_cyc)
      else $error("Data bus cycle dropped before ack");

   assert property (@(posedge i_clk) disable iff (i_rst)
                    $rose(exec.cnt_en) |-> exec.cnt == '0)
      else $error("Execute did not start at bit 0");

endmodule

`default_nettype wire

//--- hw/serv_exec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface serv_exec_if;
   import serv_pkg::*;

   logic             cnt_en;
   logic [CNT_W-1:0] cnt;
   logic             cnt_done;
   alu_op_e          alu_op;
   logic             op_b_imm;
   logic             imm_bit;
   logic             rd_wen;
   logic             is_store;
   logic             alu_rd;

   modport state  (output cnt_en, cnt, cnt_done, input is_store);
   modport decode (input cnt_en, output alu_op, op_b_imm, imm_bit, rd_wen, is_store);
   modport alu    (input cnt_en, cnt, alu_op, op_b_imm, imm_bit, output alu_rd);
   modport mem    (input cnt_en, cnt, imm_bit, is_store);

endinterface

`default_nettype wire

//--- hw/serv_pkg.sv
`default_nettype none

package serv_pkg;

   localparam int XLEN   = 32;
   localparam int REG_AW = 5;
   localparam int CNT_W  = 5;

   // RV32I major opcodes in the supported subset
   typedef enum logic [6:0] {
      OPC_OPIMM = 7'b0010011,
      OPC_STORE = 7'b0100011,
      OPC_OP    = 7'b0110011
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4
   } alu_op_e;

   typedef enum logic [1:0] {
      ST_FETCH = 2'd0,
      ST_EXEC  = 2'd1,
      ST_STORE = 2'd2
   } state_e;

endpackage

`default_nettype wire
